/* rtl/gbCorePkg.sv */
package gbCorePkg;

  // --------------------------------------------------
  // Widths
  localparam int addrWidth = 16;
  localparam int dataWidth = 8;
  localparam int uPcWidth  = 6;

  // Register field codes of the Z80 opcode map
  typedef enum logic [2:0] {
    regB, regC, regD, regE, regH, regL, regMem, regA
  } regCode;

  // --------------------------------------------------
  // Microcode word
  typedef enum logic [3:0] {
    uNop,
    uReadPc,    // PC to bus, advance PC
    uDispatch,  // Opcode into IR, jump to its flow
    uReadHl,
    uLoadDst,
    uLoadTmp,   // Jump offset byte
    uMove,
    uAluOp,
    uIncDec,
    uRotA,
    uWriteHl,
    uJumpRel
  } uopCmd;

  typedef enum logic [2:0] {
    eContinue, eEnd, eEndIfZClr, eEndIfZSet, eEndIfCClr, eEndIfCSet
  } flowEnd;

  typedef struct packed {
    uopCmd  cmd;
    flowEnd endCode;
  } uopWord;

  typedef enum logic [1:0] {
    sReset, sRun, sEnd
  } seqState;

  // --------------------------------------------------
  // Flow entry points in the microcode ROM
  localparam logic [uPcWidth-1:0] fetchFlow  = 6'd0;
  localparam logic [uPcWidth-1:0] flowNop    = 6'd2;
  localparam logic [uPcWidth-1:0] flowLdImm  = 6'd3;
  localparam logic [uPcWidth-1:0] flowMove   = 6'd5;
  localparam logic [uPcWidth-1:0] flowLdMem  = 6'd6;
  localparam logic [uPcWidth-1:0] flowStMem  = 6'd8;
  localparam logic [uPcWidth-1:0] flowAlu    = 6'd9;
  localparam logic [uPcWidth-1:0] flowAluMem = 6'd10;
  localparam logic [uPcWidth-1:0] flowIncDec = 6'd12;
  localparam logic [uPcWidth-1:0] flowRotA   = 6'd13;
  localparam logic [uPcWidth-1:0] flowJr     = 6'd14;
  localparam logic [uPcWidth-1:0] flowJrNz   = 6'd17;
  localparam logic [uPcWidth-1:0] flowJrZ    = 6'd20;
  localparam logic [uPcWidth-1:0] flowJrNc   = 6'd23;
  localparam logic [uPcWidth-1:0] flowJrC    = 6'd26;
  localparam int                  romWords   = 29;   // Populated words

  // Flags after reset
  localparam logic flagsResetZ = 1'b1;
  localparam logic flagsResetC = 1'b1;

endpackage

/* rtl/microcodeStore.sv */
module microcodeStore
(
  input  logic [gbCorePkg::uPcWidth-1:0]  uPc,
  input  logic [gbCorePkg::dataWidth-1:0] opcode,
  output gbCorePkg::uopCmd                cmd,
  output gbCorePkg::flowEnd               endCode,
  output logic [gbCorePkg::uPcWidth-1:0]  flowStart
);

  gbCorePkg::uopWord word;

  // --------------------------------------------------
  // Opcode to flow table
  always_comb
  begin
    casez (opcode)
      8'h34, 8'h35, 8'h36, 8'h76,
      8'b1000_1???, 8'b1001_1???:  flowStart = gbCorePkg::flowNop;  // Not in the subset
      8'b00??_?110:  flowStart = gbCorePkg::flowLdImm;
      8'b00??_?10?:  flowStart = gbCorePkg::flowIncDec;
      8'h17, 8'h1f:  flowStart = gbCorePkg::flowRotA;
      8'h18:         flowStart = gbCorePkg::flowJr;
      8'h20:         flowStart = gbCorePkg::flowJrNz;
      8'h28:         flowStart = gbCorePkg::flowJrZ;
      8'h30:         flowStart = gbCorePkg::flowJrNc;
      8'h38:         flowStart = gbCorePkg::flowJrC;
      8'b01??_?110:  flowStart = gbCorePkg::flowLdMem;
      8'b0111_0???:  flowStart = gbCorePkg::flowStMem;
      8'b01??_????:  flowStart = gbCorePkg::flowMove;
      8'b10??_?110:  flowStart = gbCorePkg::flowAluMem;
      8'b10??_????:  flowStart = gbCorePkg::flowAlu;
      default:       flowStart = gbCorePkg::flowNop;
    endcase
  end

  // --------------------------------------------------
  // Microcode ROM
  always_comb
  begin
    case (uPc)
      gbCorePkg::fetchFlow, gbCorePkg::flowLdImm,
      gbCorePkg::flowJr, gbCorePkg::flowJrNz, gbCorePkg::flowJrZ,
      gbCorePkg::flowJrNc, gbCorePkg::flowJrC:
        word = '{gbCorePkg::uReadPc, gbCorePkg::eContinue};
      gbCorePkg::fetchFlow + 6'd1:
        word = '{gbCorePkg::uDispatch, gbCorePkg::eContinue};
      gbCorePkg::flowLdImm + 6'd1, gbCorePkg::flowLdMem + 6'd1:
        word = '{gbCorePkg::uLoadDst, gbCorePkg::eEnd};
      gbCorePkg::flowMove:
        word = '{gbCorePkg::uMove, gbCorePkg::eEnd};
      gbCorePkg::flowLdMem, gbCorePkg::flowAluMem:
        word = '{gbCorePkg::uReadHl, gbCorePkg::eContinue};
      gbCorePkg::flowStMem:
        word = '{gbCorePkg::uWriteHl, gbCorePkg::eEnd};
      gbCorePkg::flowAlu, gbCorePkg::flowAluMem + 6'd1:
        word = '{gbCorePkg::uAluOp, gbCorePkg::eEnd};
      gbCorePkg::flowIncDec:
        word = '{gbCorePkg::uIncDec, gbCorePkg::eEnd};
      gbCorePkg::flowRotA:
        word = '{gbCorePkg::uRotA, gbCorePkg::eEnd};
      gbCorePkg::flowJr + 6'd1:
        word = '{gbCorePkg::uLoadTmp, gbCorePkg::eContinue};
      gbCorePkg::flowJrNz + 6'd1:   // Skip the jump when Z is set
        word = '{gbCorePkg::uLoadTmp, gbCorePkg::eEndIfZSet};
      gbCorePkg::flowJrZ + 6'd1:
        word = '{gbCorePkg::uLoadTmp, gbCorePkg::eEndIfZClr};
      gbCorePkg::flowJrNc + 6'd1:
        word = '{gbCorePkg::uLoadTmp, gbCorePkg::eEndIfCSet};
      gbCorePkg::flowJrC + 6'd1:
        word = '{gbCorePkg::uLoadTmp, gbCorePkg::eEndIfCClr};
      gbCorePkg::flowJr + 6'd2, gbCorePkg::flowJrNz + 6'd2, gbCorePkg::flowJrZ + 6'd2,
      gbCorePkg::flowJrNc + 6'd2, gbCorePkg::flowJrC + 6'd2:
        word = '{gbCorePkg::uJumpRel, gbCorePkg::eEnd};
      default:                      // NOP flow and unused words
        word = '{gbCorePkg::uNop, gbCorePkg::eEnd};
    endcase
  end

  assign cmd     = word.cmd;
  assign endCode = word.endCode;

endmodule

/* rtl/flowSequencer.sv */
module flowSequencer
(
  input  logic                           iClock,
  input  logic                           rst,
  input  gbCorePkg::uopCmd               cmd,
  input  gbCorePkg::flowEnd              endCode,
  input  logic [gbCorePkg::uPcWidth-1:0] flowStart,
  input  logic                           flagZ,
  input  logic                           flagC,
  output logic [gbCorePkg::uPcWidth-1:0] uPc,
  output logic                           flowActive
);

  gbCorePkg::seqState state;
  logic               endHit;   // Flow ends after this word

  always_comb
  begin
    case (endCode)
      gbCorePkg::eEnd:        endHit = 1'b1;
      gbCorePkg::eEndIfZClr:  endHit = ~flagZ;
      gbCorePkg::eEndIfZSet:  endHit = flagZ;
      gbCorePkg::eEndIfCClr:  endHit = ~flagC;
      gbCorePkg::eEndIfCSet:  endHit = flagC;
      default:                endHit = 1'b0;
    endcase
  end

  assign flowActive = (state == gbCorePkg::sRun);

  // --------------------------------------------------
  // Run state and micro-program counter
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      state <= gbCorePkg::sReset;
      uPc   <= gbCorePkg::fetchFlow;
    end
    else
    begin
      case (state)
        gbCorePkg::sRun:
        begin
          if (cmd == gbCorePkg::uDispatch)
            uPc <= flowStart;
          else if (endHit)
            state <= gbCorePkg::sEnd;
          else
            uPc <= uPc + 1'b1;
        end
        default:                   // Leaving reset or a finished flow
        begin
          state <= gbCorePkg::sRun;
          uPc   <= gbCorePkg::fetchFlow;
        end
      endcase
    end
  end

  // Every flow must end inside the populated ROM
  assert property (@(posedge iClock) disable iff (rst)
    flowActive |-> uPc < gbCorePkg::romWords);

endmodule

/* rtl/registerFile.sv */
module registerFile
(
  input  logic                            iClock,
  input  logic                            rst,
  input  logic                            flowActive,
  input  gbCorePkg::uopCmd                cmd,
  input  logic [gbCorePkg::dataWidth-1:0] dataIn,
  input  logic [gbCorePkg::dataWidth-1:0] aluResult,
  input  logic                            aluZ,
  input  logic                            aluC,
  output logic [gbCorePkg::dataWidth-1:0] opcode,
  output logic [gbCorePkg::dataWidth-1:0] srcData,
  output logic [gbCorePkg::dataWidth-1:0] accum,
  output logic [gbCorePkg::addrWidth-1:0] hlPair,
  output logic [gbCorePkg::dataWidth-1:0] jumpOffset,
  output logic                            flagZ,
  output logic                            flagC
);

  logic [gbCorePkg::dataWidth-1:0] gpr [8];   // Indexed by register code
  gbCorePkg::regCode               dstCode;
  gbCorePkg::regCode               srcCode;

  // INC and DEC work on the destination field
  assign dstCode = gbCorePkg::regCode'(opcode[5:3]);
  assign srcCode = gbCorePkg::regCode'((cmd == gbCorePkg::uIncDec) ? opcode[5:3] : opcode[2:0]);

  assign srcData = (srcCode == gbCorePkg::regMem) ? dataIn : gpr[srcCode];
  assign accum   = gpr[gbCorePkg::regA];
  assign hlPair  = {gpr[gbCorePkg::regH], gpr[gbCorePkg::regL]};

  // --------------------------------------------------
  // Register and flag writes
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      for (int i = 0; i < 8; i++)
        gpr[i] <= '0;
      opcode <= '0;
      flagZ  <= gbCorePkg::flagsResetZ;
      flagC  <= gbCorePkg::flagsResetC;
    end
    else if (flowActive)
    begin
      case (cmd)
        gbCorePkg::uDispatch:  opcode       <= dataIn;
        gbCorePkg::uLoadDst:   gpr[dstCode] <= dataIn;
        gbCorePkg::uMove:      gpr[dstCode] <= srcData;
        gbCorePkg::uAluOp:
        begin
          if (opcode[5:3] != 3'b111)       // CP only sets flags
            gpr[gbCorePkg::regA] <= aluResult;
          flagZ <= aluZ;
          flagC <= aluC;
        end
        gbCorePkg::uIncDec:
        begin
          gpr[dstCode] <= aluResult;
          flagZ        <= aluZ;
          flagC        <= aluC;
        end
        gbCorePkg::uRotA:
        begin
          gpr[gbCorePkg::regA] <= aluResult;
          flagC                <= aluC;   // Z kept
        end
        default:
        begin
        end
      endcase
    end
  end

  always_ff @(posedge iClock)
  begin
    if (flowActive && cmd == gbCorePkg::uLoadTmp)
      jumpOffset <= dataIn;
  end

  // The opcode table must never route a register write to the memory slot
  assert property (@(posedge iClock) disable iff (rst)
    flowActive && (cmd inside {gbCorePkg::uLoadDst, gbCorePkg::uMove, gbCorePkg::uIncDec})
    |-> dstCode != gbCorePkg::regMem);

endmodule

/* rtl/aluUnit.sv */
module aluUnit
(
  input  gbCorePkg::uopCmd                cmd,
  input  logic [gbCorePkg::dataWidth-1:0] opcode,
  input  logic [gbCorePkg::dataWidth-1:0] accum,
  input  logic [gbCorePkg::dataWidth-1:0] srcData,
  input  logic                            flagC,
  output logic [gbCorePkg::dataWidth-1:0] aluResult,
  output logic                            aluZ,
  output logic                            aluC
);

  logic [gbCorePkg::dataWidth:0] wide;   // Carry or borrow in the top bit

  // --------------------------------------------------
  // Result select
  always_comb
  begin
    case (cmd)
      gbCorePkg::uIncDec:                // Opcode bit 0 picks DEC
        wide = {flagC, opcode[0] ? srcData - 8'd1 : srcData + 8'd1};
      gbCorePkg::uRotA:
      begin
        if (opcode[3])                   // RRA
          wide = {accum[0], flagC, accum[7:1]};
        else                             // RLA
          wide = {accum[7], accum[6:0], flagC};
      end
      gbCorePkg::uAluOp:
      begin
        case (opcode[5:3])
          3'b000:          wide = {1'b0, accum} + {1'b0, srcData};   // ADD
          3'b010, 3'b111:  wide = {1'b0, accum} - {1'b0, srcData};   // SUB and CP
          3'b100:          wide = {1'b0, accum & srcData};
          3'b101:          wide = {1'b0, accum ^ srcData};
          3'b110:          wide = {1'b0, accum | srcData};
          default:         wide = {flagC, accum};
        endcase
      end
      default:
        wide = {flagC, accum};
    endcase
  end

  assign aluResult = wide[gbCorePkg::dataWidth-1:0];
  assign aluC      = wide[gbCorePkg::dataWidth];
  assign aluZ      = (aluResult == '0);

endmodule

/* rtl/addressUnit.sv */
module addressUnit
(
  input  logic                            iClock,
  input  logic                            rst,
  input  logic                            flowActive,
  input  gbCorePkg::uopCmd                cmd,
  input  logic [gbCorePkg::addrWidth-1:0] hlPair,
  input  logic [gbCorePkg::dataWidth-1:0] jumpOffset,
  input  logic [gbCorePkg::dataWidth-1:0] srcData,
  output logic [gbCorePkg::addrWidth-1:0] addr,
  output logic [gbCorePkg::dataWidth-1:0] dataOut,
  output logic                            readRequest,
  output logic                            writeEnable
);

  logic [gbCorePkg::addrWidth-1:0] pc;
  logic [gbCorePkg::addrWidth-1:0] readAddr;    // Bus address for the data cycle
  logic [gbCorePkg::addrWidth-1:0] jumpDelta;

  assign jumpDelta =
    {{(gbCorePkg::addrWidth - gbCorePkg::dataWidth){jumpOffset[7]}}, jumpOffset};

  // --------------------------------------------------
  // PC and read address
  always_ff @(posedge iClock)
  begin
    if (rst)
    begin
      pc          <= '0;
      readAddr    <= '0;
      readRequest <= 1'b0;
    end
    else
    begin
      // Data shows up in the cycle after the read micro-op
      readRequest <= flowActive && (cmd inside {gbCorePkg::uReadPc, gbCorePkg::uReadHl});
      if (flowActive)
      begin
        case (cmd)
          gbCorePkg::uReadPc:
          begin
            readAddr <= pc;
            pc       <= pc + 1'b1;
          end
          gbCorePkg::uReadHl:   readAddr <= hlPair;
          gbCorePkg::uJumpRel:  pc       <= pc + jumpDelta;
          default:
          begin
          end
        endcase
      end
    end
  end

  assign writeEnable = flowActive && (cmd == gbCorePkg::uWriteHl);
  assign addr        = writeEnable ? hlPair : readAddr;
  assign dataOut     = srcData;   // Source field register for LD (HL),r

  // No flow places a write right after a read
  assert property (@(posedge iClock) disable iff (rst)
    !(readRequest && writeEnable));

endmodule

/* rtl/gbCore.sv */
module gbCore
(
  input  logic                            iClock,
  input  logic                            rst,
  input  logic [gbCorePkg::dataWidth-1:0] dataIn,
  output logic [gbCorePkg::addrWidth-1:0] addr,
  output logic [gbCorePkg::dataWidth-1:0] dataOut,
  output logic                            readRequest,
  output logic                            writeEnable
);

  logic [gbCorePkg::uPcWidth-1:0]  uPc;
  logic [gbCorePkg::uPcWidth-1:0]  flowStart;
  gbCorePkg::uopCmd                cmd;
  gbCorePkg::flowEnd               endCode;
  logic                            flowActive;
  logic                            flagZ;
  logic                            flagC;
  logic [gbCorePkg::dataWidth-1:0] opcode;
  logic [gbCorePkg::dataWidth-1:0] srcData;
  logic [gbCorePkg::dataWidth-1:0] accum;
  logic [gbCorePkg::addrWidth-1:0] hlPair;
  logic [gbCorePkg::dataWidth-1:0] jumpOffset;
  logic [gbCorePkg::dataWidth-1:0] aluResult;
  logic                            aluZ;
  logic                            aluC;

  // --------------------------------------------------
  // Control path
  flowSequencer seq (
    .iClock(iClock), .rst(rst), .cmd(cmd), .endCode(endCode), .flowStart(flowStart),
    .flagZ(flagZ), .flagC(flagC), .uPc(uPc), .flowActive(flowActive)
  );

  microcodeStore ucode (
    .uPc(uPc), .opcode(dataIn),     // Opcode byte is on the bus at dispatch
    .cmd(cmd), .endCode(endCode), .flowStart(flowStart)
  );

  // --------------------------------------------------
  // Data path
  registerFile regs (
    .iClock(iClock), .rst(rst), .flowActive(flowActive), .cmd(cmd), .dataIn(dataIn),
    .aluResult(aluResult), .aluZ(aluZ), .aluC(aluC), .opcode(opcode), .srcData(srcData),
    .accum(accum), .hlPair(hlPair), .jumpOffset(jumpOffset), .flagZ(flagZ), .flagC(flagC)
  );

  aluUnit alu (
    .cmd(cmd), .opcode(opcode), .accum(accum), .srcData(srcData), .flagC(flagC),
    .aluResult(aluResult), .aluZ(aluZ), .aluC(aluC)
  );

  addressUnit bus (
    .iClock(iClock), .rst(rst), .flowActive(flowActive), .cmd(cmd), .hlPair(hlPair),
    .jumpOffset(jumpOffset), .srcData(srcData), .addr(addr), .dataOut(dataOut),
    .readRequest(readRequest), .writeEnable(writeEnable)
  );

endmodule

/* include/isaModel.svh */
// Expected bus access and the behavior it checks
typedef struct packed {
  logic        isWrite;
  logic [2:0]  tag;
  logic [15:0] where;
  logic [7:0]  value;
} busEvent;

busEvent    expQ [$];
logic [7:0] modelMem [65536];

task automatic expectAccess(input logic isWrite, input logic [2:0] tag,
                            input logic [15:0] where, input logic [7:0] value);
  busEvent ev;
  ev.isWrite = isWrite;
  ev.tag     = tag;
  ev.where   = where;
  ev.value   = value;
  expQ.push_back(ev);
endtask

// --------------------------------------------------
// Instruction-level run from reset up to the final self-jump
task automatic runModel(input logic [15:0] stopAt);
  logic [7:0]  r [8];      // B C D E H L unused A
  logic [15:0] pc;
  logic [15:0] hl;
  logic [7:0]  op;
  logic [7:0]  src;
  logic [7:0]  res;
  logic [8:0]  sum;
  logic        z;
  logic        c;
  logic        taken;
  logic [2:0]  nextTag;
  pc      = 16'h0000;
  z       = 1'b1;
  c       = 1'b1;
  nextTag = 3'd5;          // First fetch after reset
  for (int i = 0; i < 8; i++)
    r[i] = 8'h00;
  for (int i = 0; i < 65536; i++)
    modelMem[i] = mem[i];
  while (pc != stopAt)
  begin
    hl = {r[4], r[5]};
    op = modelMem[pc];
    expectAccess(1'b0, nextTag, pc, op);
    nextTag = 3'd1;
    pc      = pc + 16'd1;
    casez (op)
      8'h18, 8'h20, 8'h28, 8'h30, 8'h38:
      begin
        res = modelMem[pc];
        expectAccess(1'b0, 3'd1, pc, res);
        pc = pc + 16'd1;
        case (op[5:3])
          3'd4:    taken = !z;
          3'd5:    taken = z;
          3'd6:    taken = !c;
          3'd7:    taken = c;
          default: taken = 1'b1;
        endcase
        if (taken)
          pc = pc + {{8{res[7]}}, res};   // Relative to the byte after JR
        if (op != 8'h18)
          nextTag = 3'd4;  // Landing fetch shows the branch decision
      end
      8'b00???110:
      begin
        r[op[5:3]] = modelMem[pc];
        expectAccess(1'b0, 3'd1, pc, modelMem[pc]);
        pc = pc + 16'd1;
      end
      8'b00???10?:
      begin
        res        = op[0] ? r[op[5:3]] - 8'd1 : r[op[5:3]] + 8'd1;
        r[op[5:3]] = res;
        z          = (res == 8'h00);  // Carry untouched
      end
      8'h17:
      begin
        res  = {r[7][6:0], c};
        c    = r[7][7];
        r[7] = res;
      end
      8'h1f:
      begin
        res  = {c, r[7][7:1]};
        c    = r[7][0];
        r[7] = res;
      end
      8'b01110???:
      begin
        expectAccess(1'b1, 3'd2, hl, r[op[2:0]]);
        if (hl[15])
          modelMem[hl] = r[op[2:0]];   // Lower half is ROM
      end
      8'b01???110:
      begin
        r[op[5:3]] = modelMem[hl];
        expectAccess(1'b0, 3'd3, hl, modelMem[hl]);
      end
      8'b01??????:  r[op[5:3]] = r[op[2:0]];
      8'b10??????:
      begin
        src = r[op[2:0]];
        if (op[2:0] == 3'd6)
        begin
          src = modelMem[hl];
          expectAccess(1'b0, 3'd3, hl, src);
        end
        sum = {1'b0, r[7]} + {1'b0, src};
        case (op[5:3])
          3'd0:
          begin
            res = sum[7:0];
            c   = sum[8];
          end
          3'd4:
          begin
            res = r[7] & src;
            c   = 1'b0;
          end
          3'd5:
          begin
            res = r[7] ^ src;
            c   = 1'b0;
          end
          3'd6:
          begin
            res = r[7] | src;
            c   = 1'b0;
          end
          default:         // SUB and CP borrow when the operand is larger
          begin
            res = r[7] - src;
            c   = (src > r[7]);
          end
        endcase
        z = (res == 8'h00);
        if (op[5:3] != 3'd7)
          r[7] = res;
      end
      default:
      begin
      end
    endcase
  end
  // One pass through the self-jump
  expectAccess(1'b0, 3'd5, pc, modelMem[pc]);
  expectAccess(1'b0, 3'd5, pc + 16'd1, modelMem[pc + 16'd1]);
endtask

/* tests/gbCoreTb.sv */
module gbCoreTb;

  localparam int progLen    = 200;
  localparam int drainReads = 6;   // Accesses checked inside the final loop

  logic        iClock;
  logic        rst;
  logic [7:0]  dataIn;
  logic [15:0] addr;
  logic [7:0]  dataOut;
  logic        readRequest;
  logic        writeEnable;

  logic [7:0]  mem [65536];
  logic [15:0] endAddr;
  int          seed;
  int          cycles;
  int          cycleLimit;
  int          drained;
  bit          timedOut;
  int          checks [6];
  int          errors [6];
  int          totalChecks;
  int          totalErrors;

  `include "isaModel.svh"

  gbCore dut (
    .iClock(iClock), .rst(rst), .dataIn(dataIn), .addr(addr), .dataOut(dataOut),
    .readRequest(readRequest), .writeEnable(writeEnable)
  );

  assign dataIn = mem[addr];   // Asynchronous read

  // Writes land in the upper half only
  always @(posedge iClock)
  begin
    if (writeEnable && addr[15])
      mem[addr] <= dataOut;
  end

  initial
  begin
    iClock = 1'b0;
    forever #10 iClock = ~iClock;
  end

  function automatic int randBelow(input int n);
    return {$random(seed)} % n;
  endfunction

  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = 3'(randBelow(7));
    return (r == 3'd6) ? 3'd7 : r;   // Never the (HL) slot
  endfunction

  function automatic logic [2:0] pickAluOp();
    logic [2:0] o;
    o = 3'(randBelow(6) + 2);
    return (o == 3'd3) ? 3'd0 : o;   // ADD SUB AND XOR OR CP
  endfunction

  function automatic string testName(input int tag);
    case (tag)
      1:       return "fetch order";
      2:       return "store data";
      3:       return "HL reads";
      4:       return "conditional JR";
      default: return "reset and end";
    endcase
  endfunction

  // --------------------------------------------------
  // Random program with forward jumps only
  task automatic buildProgram;
    int         p;
    int         t;
    int         kind;
    logic [2:0] d;
    logic [2:0] s;
    bit         isStart [256];
    int         jrAt [$];
    for (int i = 0; i < 65536; i++)
      mem[i] = i[15:8] ^ i[7:0] ^ 8'ha5;
    for (int i = 0; i < 256; i++)
      isStart[i] = 1'b0;
    p = 0;
    while (p < progLen - 2)
    begin
      isStart[p] = 1'b1;
      d          = pickReg();
      s          = pickReg();
      kind       = randBelow(10);
      case (kind)
        0: mem[p] = 8'h00;
        1:
        begin
          mem[p]     = {2'b00, d, 3'b110};
          mem[p + 1] = 8'(randBelow(256));
          if (d == 3'd4)
            mem[p + 1] = {6'b100000, mem[p + 1][1:0]};   // H points into RAM
          else if (d == 3'd5)
            mem[p + 1][7:4] = 4'h0;   // Few L values so stores get read back
        end
        2: mem[p] = {2'b01, d, s};
        3: mem[p] = {2'b01, d, 3'b110};
        4: mem[p] = {5'b01110, s};
        5: mem[p] = {2'b10, pickAluOp(), s};
        6: mem[p] = {2'b10, pickAluOp(), 3'b110};
        7: mem[p] = {2'b00, d, 2'b10, 1'(randBelow(2))};
        8: mem[p] = randBelow(2) ? 8'h1f : 8'h17;
        default:
        begin
          mem[p] = (randBelow(5) == 0) ? 8'h18 : {3'b001, 2'(randBelow(4)), 3'b000};
          jrAt.push_back(p);
        end
      endcase
      p = p + ((kind == 1 || kind == 9) ? 2 : 1);
    end
    endAddr    = 16'(p);
    isStart[p] = 1'b1;
    mem[p]     = 8'h18;
    mem[p + 1] = 8'hfe;               // JR to itself
    foreach (jrAt[k])
    begin
      t = jrAt[k] + 2 + randBelow(12);
      if (t > p)
        t = p;
      while (!isStart[t])
        t++;                          // Land on an instruction boundary
      mem[jrAt[k] + 1] = 8'(t - jrAt[k] - 2);
    end
  endtask

  // --------------------------------------------------
  // Bus monitor sampled mid-cycle
  always @(negedge iClock)
  begin
    busEvent ev;
    if (rst)
    begin
      checks[5]++;
      assert (!readRequest && !writeEnable)
      else
      begin
        $display("reset and end: bus strobes active while in reset");
        errors[5]++;
      end
    end
    else if (readRequest || writeEnable)
    begin
      if (expQ.size() == 0)
      begin
        checks[5]++;
        drained++;
        assert (!writeEnable)
        else
        begin
          $display("reset and end: bus write during the final self-jump");
          errors[5]++;
        end
        assert (addr == endAddr || addr == endAddr + 16'd1)
        else
        begin
          $display("** Error reset and end: address expected %h or %h actual %h",
                   endAddr, endAddr + 16'd1, addr);
          errors[5]++;
        end
      end
      else
      begin
        ev = expQ.pop_front();
        checks[ev.tag]++;
        assert (writeEnable == ev.isWrite)
        else
        begin
          $display("%s: bus %s where the model expects a %s", testName(ev.tag),
                   writeEnable ? "write" : "read", ev.isWrite ? "write" : "read");
          errors[ev.tag]++;
        end
        assert (addr == ev.where)
        else
        begin
          $display("** Error %s: address expected %h actual %h",
                   testName(ev.tag), ev.where, addr);
          errors[ev.tag]++;
        end
        if (ev.isWrite)
          assert (dataOut == ev.value)
          else
          begin
            $display("** Error %s: data expected %h actual %h",
                     testName(ev.tag), ev.value, dataOut);
            errors[ev.tag]++;
          end
      end
    end
  end

  initial
  begin
    seed     = 32'hf7ec;
    rst      = 1'b1;
    cycles   = 0;
    drained  = 0;
    timedOut = 1'b0;
    buildProgram();
    runModel(endAddr);
    cycleLimit = (int'(endAddr) + 2) * 8 + 100;
    repeat (2) @(posedge iClock);
    rst <= 1'b0;
    while (drained < drainReads && !timedOut)
    begin
      @(posedge iClock);
      cycles++;
      if (cycles >= cycleLimit)
        timedOut = 1'b1;
    end
    if (timedOut)
      $display("reset and end: timeout after %0d cycles with %0d accesses still expected",
               cycles, expQ.size());
    totalChecks = 0;
    totalErrors = timedOut ? 1 : 0;
    for (int t = 1; t <= 5; t++)
    begin
      $display("%s: %0d checks, %0d errors", testName(t), checks[t], errors[t]);
      totalChecks += checks[t];
      totalErrors += errors[t];
    end
    $display("Totals: %0d checks, %0d errors, %0d cycles", totalChecks, totalErrors, cycles);
    if (totalErrors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

/* src.f */
+incdir+include
rtl/gbCorePkg.sv
rtl/microcodeStore.sv
rtl/flowSequencer.sv
rtl/registerFile.sv
rtl/aluUnit.sv
rtl/addressUnit.sv
rtl/gbCore.sv
tests/gbCoreTb.sv

/* run.sh */
#!/bin/sh
# Build the gbCore testbench with Verilator, run it, then look for the pass message
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --top-module gbCoreTb -f src.f > build.log 2>&1 &&
./obj_dir/VgbCoreTb > sim.log 2>&1 ||
echo "Build or run error, see build.log and sim.log"
grep -q "Simulation completed successfully" sim.log && echo PASS || { echo FAIL; exit 1; }
